// ==== Makefile ====
# Verilator simulation of the Port C block

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_ppi_port_c \
		-f ppi_port_c.f -o tb_ppi_port_c
	@out="$$(./obj_dir/tb_ppi_port_c)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== design/ppi_handshake.sv ====
//////////////////////////////////////////////////
// Mode-1 handshake of one group, combinational next values.
// Only the CPU read level is registered, for edge detection.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ppi_handshake (
    input  wire                  reset,
    input  wire                  clock,
    input  wire ppi_mode_pkg::mode_t mode,
    input  wire                  port_dir,
    input  wire                  inte,
    input  wire                  stb_pin,
    input  wire                  stb_pin_dir,
    input  wire                  ack_pin,
    input  wire                  ack_pin_dir,
    input  wire                  ibf_cur,
    input  wire                  obf_n_cur,
    input  wire                  intr_cur,
    input  wire                  read_port,
    input  wire                  write_port,
    output logic                 strobe,
    output logic                 ack_n,
    output logic                 ibf_next,
    output logic                 obf_n_next,
    output logic                 intr_next
);

    logic stb_n;
    logic read_q;
    logic read_rise;
    logic read_fall;

    // Pins driven by the device read as inactive
    assign stb_n = (stb_pin_dir == ppi_mode_pkg::PORT_INPUT) ? stb_pin : 1'b1;
    assign ack_n = (ack_pin_dir == ppi_mode_pkg::PORT_INPUT) ? ack_pin : 1'b1;
    assign strobe = ~stb_n;

    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            read_q <= 1'b0;
        end else begin
            read_q <= read_port;
        end
    end

    assign read_rise = read_port & ~read_q;
    assign read_fall = ~read_port & read_q;

    // Input buffer full
    always_comb begin
        ibf_next = ibf_cur;
        if (port_dir == ppi_mode_pkg::PORT_INPUT) begin
            if (!stb_n) begin
                ibf_next = 1'b1;
            end
            if (read_fall) begin
                ibf_next = 1'b0;
            end
        end
    end

    // Output buffer full, active low
    always_comb begin
        obf_n_next = obf_n_cur;
        if (port_dir == ppi_mode_pkg::PORT_OUTPUT) begin
            if (write_port) begin
                obf_n_next = 1'b0;
            end
            if (!ack_n) begin
                obf_n_next = 1'b1;
            end
        end
    end

    always_comb begin
        intr_next = intr_cur;
        if (mode == ppi_mode_pkg::MODE_1) begin
            if (port_dir == ppi_mode_pkg::PORT_INPUT) begin
                if (stb_n && ibf_next && inte) begin
                    intr_next = 1'b1;
                end
                if (read_rise) begin
                    intr_next = 1'b0;
                end
            end else begin
                if (ack_n && obf_n_next && inte) begin
                    intr_next = 1'b1;
                end
                if (write_port) begin
                    intr_next = 1'b0;
                end
            end
            // Interrupt disabled by INTE
            if (!inte) begin
                intr_next = 1'b0;
            end
        end
    end

    a_read_write_apart: assert property (
        @(posedge reset) disable iff (clock) !(read_port && write_port)
    );

endmodule

`default_nettype wire

// ==== design/ppi_mode_pkg.sv ====
//////////////////////////////////////////////////
// Control word fields of the 8255 control port.
// Mode 2 has no encoding here.
// A Group A mode value of 2 behaves as mode 0.
//////////////////////////////////////////////////
`default_nettype none

package ppi_mode_pkg;

    // Group mode code
    typedef logic [1:0] mode_t;

    localparam mode_t MODE_0 = 2'd0;
    localparam mode_t MODE_1 = 2'd1;

    // Direction of a port or a single pin
    localparam logic PORT_INPUT  = 1'b1;
    localparam logic PORT_OUTPUT = 1'b0;

    // Mode set word on the data bus
    localparam int CW_A_MODE_LSB = 5;
    localparam int CW_A_DIR_BIT  = 4;
    localparam int CW_B_MODE_BIT = 2;
    localparam int CW_B_DIR_BIT  = 1;

    // Bit set/reset word
    localparam int BSR_SEL_LSB   = 1;
    localparam int BSR_VALUE_BIT = 0;

endpackage

`default_nettype wire

// ==== design/ppi_pin_pkg.sv ====
//////////////////////////////////////////////////
// Port C pin roles while a group runs mode 1.
// Port C is fixed at eight pins.
//////////////////////////////////////////////////
`default_nettype none

package ppi_pin_pkg;

    localparam int PC_WIDTH = 8;

    // Group B
    localparam int PC_INTR_B = 0;
    localparam int PC_BUF_B  = 1;   // IBF B or /OBF B
    localparam int PC_HS_B   = 2;   // /STB B or /ACK B

    // Group A
    localparam int PC_INTR_A = 3;
    localparam int PC_STB_A  = 4;
    localparam int PC_IBF_A  = 5;
    localparam int PC_ACK_A  = 6;
    localparam int PC_OBF_A  = 7;

endpackage

`default_nettype wire

// ==== design/ppi_port_c.sv ====
//////////////////////////////////////////////////
// 8255 Port C, modes 0 and 1 for both groups.
// Mode 2 is not supported. Control register lives outside.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ppi_port_c (
    input  wire                                reset,
    input  wire                                clock,
    input  wire ppi_mode_pkg::mode_t           group_a_mode,
    input  wire ppi_mode_pkg::mode_t           group_b_mode,
    input  wire                                port_a_dir,
    input  wire                                port_b_dir,
    input  wire                                port_c_hi_dir,
    input  wire                                port_c_lo_dir,
    input  wire [7:0]                          data_bus,
    input  wire                                write_port_a,
    input  wire                                write_port_b,
    input  wire                                write_port_c,
    input  wire                                write_port_c_bit,
    input  wire                                update_group_a_mode,
    input  wire                                update_group_b_mode,
    input  wire                                read_port_a,
    input  wire                                read_port_b,
    input  wire [ppi_pin_pkg::PC_WIDTH-1:0]    port_c_in,
    output logic [ppi_pin_pkg::PC_WIDTH-1:0]   port_c_out,
    output logic [ppi_pin_pkg::PC_WIDTH-1:0]   port_c_io,
    output logic [ppi_pin_pkg::PC_WIDTH-1:0]   port_c_read,
    output logic                               port_a_strobe,
    output logic                               port_b_strobe,
    output logic                               port_a_hiz
);

    logic inte_a;
    logic inte_b;
    logic ibf_a_next;
    logic obf_n_a_next;
    logic intr_a_next;
    logic ibf_b_next;
    logic obf_n_b_next;
    logic intr_b_next;
    logic buf_b_next;

    // INTE A sits on the strobe or ack pin of the active direction
    assign inte_a = (port_a_dir == ppi_mode_pkg::PORT_INPUT) ?
                    port_c_out[ppi_pin_pkg::PC_STB_A] : port_c_out[ppi_pin_pkg::PC_ACK_A];
    assign inte_b = port_c_out[ppi_pin_pkg::PC_HS_B];

    // PC1 shares IBF B and /OBF B
    assign buf_b_next = (port_b_dir == ppi_mode_pkg::PORT_INPUT) ? ibf_b_next : obf_n_b_next;

    ppi_handshake handshake_a (
        .reset       (reset),
        .clock       (clock),
        .mode        (group_a_mode),
        .port_dir    (port_a_dir),
        .inte        (inte_a),
        .stb_pin     (port_c_in[ppi_pin_pkg::PC_STB_A]),
        .stb_pin_dir (port_c_io[ppi_pin_pkg::PC_STB_A]),
        .ack_pin     (port_c_in[ppi_pin_pkg::PC_ACK_A]),
        .ack_pin_dir (port_c_io[ppi_pin_pkg::PC_ACK_A]),
        .ibf_cur     (port_c_out[ppi_pin_pkg::PC_IBF_A]),
        .obf_n_cur   (port_c_out[ppi_pin_pkg::PC_OBF_A]),
        .intr_cur    (port_c_out[ppi_pin_pkg::PC_INTR_A]),
        .read_port   (read_port_a),
        .write_port  (write_port_a),
        .strobe      (port_a_strobe),
        .ack_n       (port_a_hiz),
        .ibf_next    (ibf_a_next),
        .obf_n_next  (obf_n_a_next),
        .intr_next   (intr_a_next)
    );

    ppi_handshake handshake_b (
        .reset       (reset),
        .clock       (clock),
        .mode        (group_b_mode),
        .port_dir    (port_b_dir),
        .inte        (inte_b),
        .stb_pin     (port_c_in[ppi_pin_pkg::PC_HS_B]),
        .stb_pin_dir (port_c_io[ppi_pin_pkg::PC_HS_B]),
        .ack_pin     (port_c_in[ppi_pin_pkg::PC_HS_B]),
        .ack_pin_dir (port_c_io[ppi_pin_pkg::PC_HS_B]),
        .ibf_cur     (port_c_out[ppi_pin_pkg::PC_BUF_B]),
        .obf_n_cur   (port_c_out[ppi_pin_pkg::PC_BUF_B]),
        .intr_cur    (port_c_out[ppi_pin_pkg::PC_INTR_B]),
        .read_port   (read_port_b),
        .write_port  (write_port_b),
        .strobe      (port_b_strobe),
        .ack_n       (),
        .ibf_next    (ibf_b_next),
        .obf_n_next  (obf_n_b_next),
        .intr_next   (intr_b_next)
    );

    ppi_portc_dir portc_dir (
        .reset         (reset),
        .clock         (clock),
        .group_a_mode  (group_a_mode),
        .group_b_mode  (group_b_mode),
        .port_a_dir    (port_a_dir),
        .port_b_dir    (port_b_dir),
        .port_c_hi_dir (port_c_hi_dir),
        .port_c_lo_dir (port_c_lo_dir),
        .port_c_io     (port_c_io)
    );

    ppi_portc_latch portc_latch (
        .reset               (reset),
        .clock               (clock),
        .data_bus            (data_bus),
        .write_port_c        (write_port_c),
        .write_port_c_bit    (write_port_c_bit),
        .update_group_a_mode (update_group_a_mode),
        .update_group_b_mode (update_group_b_mode),
        .group_a_mode        (group_a_mode),
        .group_b_mode        (group_b_mode),
        .ibf_a_next          (ibf_a_next),
        .obf_n_a_next        (obf_n_a_next),
        .intr_a_next         (intr_a_next),
        .buf_b_next          (buf_b_next),
        .intr_b_next         (intr_b_next),
        .port_c_out          (port_c_out)
    );

    ppi_portc_readback portc_readback (
        .reset               (reset),
        .clock               (clock),
        .port_c_in           (port_c_in),
        .port_c_out          (port_c_out),
        .port_c_io           (port_c_io),
        .update_group_a_mode (update_group_a_mode),
        .update_group_b_mode (update_group_b_mode),
        .port_c_read         (port_c_read)
    );

endmodule

`default_nettype wire

// ==== design/ppi_portc_dir.sv ====
//////////////////////////////////////////////////
// Port C pin directions from both group modes.
// A 1 means input. Takes effect one edge after the modes.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ppi_portc_dir (
    input  wire                  reset,
    input  wire                  clock,
    input  wire ppi_mode_pkg::mode_t group_a_mode,
    input  wire ppi_mode_pkg::mode_t group_b_mode,
    input  wire                  port_a_dir,
    input  wire                  port_b_dir,
    input  wire                  port_c_hi_dir,
    input  wire                  port_c_lo_dir,
    output logic [ppi_pin_pkg::PC_WIDTH-1:0] port_c_io
);

    logic [ppi_pin_pkg::PC_WIDTH-1:0] io_next;

    always_comb begin
        // Plain I/O by nibble unless a handshake claims the pin
        io_next = {{4{port_c_hi_dir}}, {4{port_c_lo_dir}}};

        // Group B pins keep the same directions for input and output
        if (group_b_mode == ppi_mode_pkg::MODE_1) begin
            io_next[ppi_pin_pkg::PC_INTR_B] = ppi_mode_pkg::PORT_OUTPUT;
            io_next[ppi_pin_pkg::PC_BUF_B]  = ppi_mode_pkg::PORT_OUTPUT;
            io_next[ppi_pin_pkg::PC_HS_B]   = ppi_mode_pkg::PORT_INPUT;
        end

        if (group_a_mode == ppi_mode_pkg::MODE_1) begin
            io_next[ppi_pin_pkg::PC_INTR_A] = ppi_mode_pkg::PORT_OUTPUT;
            if (port_a_dir == ppi_mode_pkg::PORT_INPUT) begin
                io_next[ppi_pin_pkg::PC_STB_A] = ppi_mode_pkg::PORT_INPUT;
                io_next[ppi_pin_pkg::PC_IBF_A] = ppi_mode_pkg::PORT_OUTPUT;
            end else begin
                io_next[ppi_pin_pkg::PC_ACK_A] = ppi_mode_pkg::PORT_INPUT;
                io_next[ppi_pin_pkg::PC_OBF_A] = ppi_mode_pkg::PORT_OUTPUT;
            end
        end
    end

    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            port_c_io <= {ppi_pin_pkg::PC_WIDTH{ppi_mode_pkg::PORT_INPUT}};
        end else begin
            port_c_io <= io_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/ppi_portc_latch.sv ====
//////////////////////////////////////////////////
// Port C output latch, one register per pin.
// Priority is bit set/reset, full write, mode update, handshake.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ppi_portc_latch (
    input  wire                  reset,
    input  wire                  clock,
    input  wire [7:0]            data_bus,
    input  wire                  write_port_c,
    input  wire                  write_port_c_bit,
    input  wire                  update_group_a_mode,
    input  wire                  update_group_b_mode,
    input  wire ppi_mode_pkg::mode_t group_a_mode,
    input  wire ppi_mode_pkg::mode_t group_b_mode,
    input  wire                  ibf_a_next,
    input  wire                  obf_n_a_next,
    input  wire                  intr_a_next,
    input  wire                  buf_b_next,
    input  wire                  intr_b_next,
    output logic [ppi_pin_pkg::PC_WIDTH-1:0] port_c_out
);

    localparam int SEL_W = $clog2(ppi_pin_pkg::PC_WIDTH);

    ppi_mode_pkg::mode_t              new_a_mode;
    ppi_mode_pkg::mode_t              new_b_mode;
    logic                             new_a_obf_n;
    logic                             new_b_obf_n;
    logic [SEL_W-1:0]                 bsr_sel;
    logic [ppi_pin_pkg::PC_WIDTH-1:0] latch_next;

    // Mode set word decode
    assign new_a_mode = data_bus[ppi_mode_pkg::CW_A_MODE_LSB +: 2];
    assign new_b_mode = data_bus[ppi_mode_pkg::CW_B_MODE_BIT] ?
                        ppi_mode_pkg::MODE_1 : ppi_mode_pkg::MODE_0;

    // /OBF idles high when the new word selects mode-1 output
    assign new_a_obf_n = (new_a_mode == ppi_mode_pkg::MODE_1) &&
                         (data_bus[ppi_mode_pkg::CW_A_DIR_BIT] == ppi_mode_pkg::PORT_OUTPUT);
    assign new_b_obf_n = (new_b_mode == ppi_mode_pkg::MODE_1) &&
                         (data_bus[ppi_mode_pkg::CW_B_DIR_BIT] == ppi_mode_pkg::PORT_OUTPUT);

    assign bsr_sel = data_bus[ppi_mode_pkg::BSR_SEL_LSB +: SEL_W];

    // Later assignments take priority
    always_comb begin
        latch_next = port_c_out;

        if (group_b_mode == ppi_mode_pkg::MODE_1) begin
            latch_next[ppi_pin_pkg::PC_INTR_B] = intr_b_next;
            latch_next[ppi_pin_pkg::PC_BUF_B]  = buf_b_next;
        end

        if (group_a_mode == ppi_mode_pkg::MODE_1) begin
            latch_next[ppi_pin_pkg::PC_INTR_A] = intr_a_next;
            latch_next[ppi_pin_pkg::PC_IBF_A]  = ibf_a_next;
            latch_next[ppi_pin_pkg::PC_OBF_A]  = obf_n_a_next;
        end

        if (update_group_b_mode) begin
            latch_next[ppi_pin_pkg::PC_HS_B:ppi_pin_pkg::PC_INTR_B] = '0;
            latch_next[ppi_pin_pkg::PC_BUF_B] = new_b_obf_n;
        end

        if (update_group_a_mode) begin
            latch_next[ppi_pin_pkg::PC_OBF_A:ppi_pin_pkg::PC_INTR_A] = '0;
            latch_next[ppi_pin_pkg::PC_OBF_A] = new_a_obf_n;
        end

        if (write_port_c) begin
            latch_next = data_bus;
        end

        // Single pin only, the others keep their lower priority update
        if (write_port_c_bit) begin
            latch_next[bsr_sel] = data_bus[ppi_mode_pkg::BSR_VALUE_BIT];
        end
    end

    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            port_c_out <= '0;
        end else begin
            port_c_out <= latch_next;
        end
    end

    a_write_kinds_apart: assert property (
        @(posedge reset) disable iff (clock) !(write_port_c && write_port_c_bit)
    );

endmodule

`default_nettype wire

// ==== design/ppi_portc_readback.sv ====
//////////////////////////////////////////////////
// Registered Port C read value.
// A nibble reads as zero in its group's mode update cycle.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ppi_portc_readback (
    input  wire                                reset,
    input  wire                                clock,
    input  wire [ppi_pin_pkg::PC_WIDTH-1:0]    port_c_in,
    input  wire [ppi_pin_pkg::PC_WIDTH-1:0]    port_c_out,
    input  wire [ppi_pin_pkg::PC_WIDTH-1:0]    port_c_io,
    input  wire                                update_group_a_mode,
    input  wire                                update_group_b_mode,
    output logic [ppi_pin_pkg::PC_WIDTH-1:0]   port_c_read
);

    localparam int HALF = ppi_pin_pkg::PC_WIDTH / 2;

    logic [ppi_pin_pkg::PC_WIDTH-1:0] read_next;

    always_comb begin
        for (int i = 0; i < ppi_pin_pkg::PC_WIDTH; i++) begin
            read_next[i] = (port_c_io[i] == ppi_mode_pkg::PORT_INPUT) ?
                           port_c_in[i] : port_c_out[i];
        end
        if (update_group_a_mode) begin
            read_next[ppi_pin_pkg::PC_WIDTH-1:HALF] = '0;
        end
        if (update_group_b_mode) begin
            read_next[HALF-1:0] = '0;
        end
    end

    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            port_c_read <= '0;
        end else begin
            port_c_read <= read_next;
        end
    end

    a_read_known: assert property (
        @(posedge reset) disable iff (clock) !$isunknown(port_c_read)
    );

endmodule

`default_nettype wire

// ==== ppi_port_c.f ====
design/ppi_mode_pkg.sv
design/ppi_pin_pkg.sv
design/ppi_handshake.sv
design/ppi_portc_dir.sv
design/ppi_portc_latch.sv
design/ppi_portc_readback.sv
design/ppi_port_c.sv
tb/tb_ppi_port_c.sv

// ==== tb/tb_ppi_port_c.sv ====
//////////////////////////////////////////////////
// The clock port is named reset and the reset port is named clock.
// A model predicts port_c_io and port_c_read. The stimulus predicts
// port_c_out step by step. CPU read pulses last one cycle.
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_ppi_port_c;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int MODE0_ROUNDS = 32;
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * MODE0_ROUNDS + 40;
    // PC6, PC4 and PC2 idle high while a group runs mode 1
    localparam logic [7:0] HS_PINS = 8'h54;

    logic                reset;
    logic                clock;
    ppi_mode_pkg::mode_t group_a_mode;
    ppi_mode_pkg::mode_t group_b_mode;
    logic                port_a_dir;
    logic                port_b_dir;
    logic                port_c_hi_dir;
    logic                port_c_lo_dir;
    logic [7:0]          data_bus;
    logic                write_port_a;
    logic                write_port_b;
    logic                write_port_c;
    logic                write_port_c_bit;
    logic                update_group_a_mode;
    logic                update_group_b_mode;
    logic                read_port_a;
    logic                read_port_b;
    logic [7:0]          port_c_in;
    logic [7:0]          port_c_out;
    logic [7:0]          port_c_io;
    logic [7:0]          port_c_read;
    logic                port_a_strobe;
    logic                port_b_strobe;
    logic                port_a_hiz;

    logic [7:0]  exp_out_next;
    logic [7:0]  exp_out;
    logic [7:0]  exp_io;
    logic [7:0]  exp_read;
    logic        exp_strobe_a;
    logic        exp_strobe_b;
    logic        exp_hiz;
    logic [7:0]  hs_mask;
    logic [7:0]  hs_level;
    logic [31:0] rnd;
    logic [31:0] stim;
    integer      seed;
    int          out_errors;
    int          read_errors;
    int          io_errors;
    int          pin_errors;

    ppi_port_c ppi_port_c_i (.*);

    // A strobe or ack pin counts only while it is an input
    assign exp_strobe_a = exp_io[ppi_pin_pkg::PC_STB_A] & ~port_c_in[ppi_pin_pkg::PC_STB_A];
    assign exp_strobe_b = exp_io[ppi_pin_pkg::PC_HS_B] & ~port_c_in[ppi_pin_pkg::PC_HS_B];
    assign exp_hiz      = ~exp_io[ppi_pin_pkg::PC_ACK_A] | port_c_in[ppi_pin_pkg::PC_ACK_A];

    // Pin directions from the mode-1 role table with 1 for input
    function automatic logic [7:0] pin_dirs(
        input ppi_mode_pkg::mode_t a_mode,
        input ppi_mode_pkg::mode_t b_mode,
        input logic                a_dir,
        input logic                hi_dir,
        input logic                lo_dir
    );
        logic [7:0] dirs;
        dirs = {{4{hi_dir}}, {4{lo_dir}}};
        if (b_mode == ppi_mode_pkg::MODE_1) begin
            dirs[ppi_pin_pkg::PC_INTR_B] = 1'b0;
            dirs[ppi_pin_pkg::PC_BUF_B]  = 1'b0;
            dirs[ppi_pin_pkg::PC_HS_B]   = 1'b1;
        end
        if (a_mode == ppi_mode_pkg::MODE_1) begin
            dirs[ppi_pin_pkg::PC_INTR_A] = 1'b0;
            if (a_dir == ppi_mode_pkg::PORT_INPUT) begin
                dirs[ppi_pin_pkg::PC_STB_A] = 1'b1;
                dirs[ppi_pin_pkg::PC_IBF_A] = 1'b0;
            end else begin
                dirs[ppi_pin_pkg::PC_ACK_A] = 1'b1;
                dirs[ppi_pin_pkg::PC_OBF_A] = 1'b0;
            end
        end
        return dirs;
    endfunction

    function automatic logic [7:0] read_value(
        input logic [7:0] dirs,
        input logic [7:0] pins,
        input logic [7:0] latch,
        input logic       upd_a,
        input logic       upd_b
    );
        logic [7:0] value;
        value = (dirs & pins) | (~dirs & latch);
        if (upd_a) begin
            value[7:4] = 4'h0;
        end
        if (upd_b) begin
            value[3:0] = 4'h0;
        end
        return value;
    endfunction

    always @(posedge reset or posedge clock) begin
        if (clock) begin
            exp_out  <= 8'h00;
            exp_io   <= 8'hff;
            exp_read <= 8'h00;
        end else begin
            exp_out  <= exp_out_next;
            exp_io   <= pin_dirs(group_a_mode, group_b_mode, port_a_dir,
                                 port_c_hi_dir, port_c_lo_dir);
            exp_read <= read_value(exp_io, port_c_in, exp_out,
                                   update_group_a_mode, update_group_b_mode);
        end
    end

    out_check: assert property (@(posedge reset) disable iff (clock) port_c_out == exp_out)
        else begin
            out_errors++;
            $display("** Error port_c_out at %0t: got %h, expected %h",
                     $time, $sampled(port_c_out), $sampled(exp_out));
        end

    io_check: assert property (@(posedge reset) disable iff (clock) port_c_io == exp_io)
        else begin
            io_errors++;
            $display("** Error port_c_io at %0t: got %h, expected %h",
                     $time, $sampled(port_c_io), $sampled(exp_io));
        end

    read_check: assert property (@(posedge reset) disable iff (clock) port_c_read == exp_read)
        else begin
            read_errors++;
            $display("** Error port_c_read at %0t: got %h, expected %h",
                     $time, $sampled(port_c_read), $sampled(exp_read));
        end

    strobe_a_check: assert property (@(posedge reset) disable iff (clock)
        port_a_strobe == exp_strobe_a)
        else begin
            pin_errors++;
            $display("** Error port_a_strobe at %0t: got %h, expected %h",
                     $time, $sampled(port_a_strobe), $sampled(exp_strobe_a));
        end

    strobe_b_check: assert property (@(posedge reset) disable iff (clock)
        port_b_strobe == exp_strobe_b)
        else begin
            pin_errors++;
            $display("** Error port_b_strobe at %0t: got %h, expected %h",
                     $time, $sampled(port_b_strobe), $sampled(exp_strobe_b));
        end

    hiz_check: assert property (@(posedge reset) disable iff (clock)
        port_a_hiz == exp_hiz)
        else begin
            pin_errors++;
            $display("** Error port_a_hiz at %0t: got %h, expected %h",
                     $time, $sampled(port_a_hiz), $sampled(exp_hiz));
        end

    task next_cycle;
        @(negedge reset);
        write_port_a = 1'b0;
        write_port_b = 1'b0;
        write_port_c = 1'b0;
        write_port_c_bit = 1'b0;
        update_group_a_mode = 1'b0;
        update_group_b_mode = 1'b0;
        data_bus = 8'h00;
        rnd = $random(seed);
        port_c_in = (rnd[7:0] & ~hs_mask) | (hs_level & hs_mask);
    endtask

    task idle(input int cycles);
        repeat (cycles) next_cycle;
    endtask

    task write_full(input logic [7:0] value);
        next_cycle;
        write_port_c = 1'b1;
        data_bus = value;
        exp_out_next = value;
    endtask

    task write_bit(input int sel, input logic value);
        next_cycle;
        write_port_c_bit = 1'b1;
        data_bus[ppi_mode_pkg::BSR_SEL_LSB +: 3] = sel[2:0];
        data_bus[ppi_mode_pkg::BSR_VALUE_BIT] = value;
        exp_out_next[sel] = value;
    endtask

    // Mode word and control register change in the same cycle
    task set_group_a(input ppi_mode_pkg::mode_t mode, input logic dir);
        next_cycle;
        update_group_a_mode = 1'b1;
        group_a_mode = mode;
        port_a_dir = dir;
        data_bus[7] = 1'b1;
        data_bus[ppi_mode_pkg::CW_A_MODE_LSB +: 2] = mode;
        data_bus[ppi_mode_pkg::CW_A_DIR_BIT] = dir;
        // Group A owns PC7 to PC3
        exp_out_next[7:3] = 5'b00000;
        exp_out_next[ppi_pin_pkg::PC_OBF_A] =
            (mode == ppi_mode_pkg::MODE_1) && (dir == ppi_mode_pkg::PORT_OUTPUT);
    endtask

    task set_group_b(input ppi_mode_pkg::mode_t mode, input logic dir);
        next_cycle;
        update_group_b_mode = 1'b1;
        group_b_mode = mode;
        port_b_dir = dir;
        data_bus[7] = 1'b1;
        data_bus[ppi_mode_pkg::CW_B_MODE_BIT] = (mode == ppi_mode_pkg::MODE_1);
        data_bus[ppi_mode_pkg::CW_B_DIR_BIT] = dir;
        exp_out_next[2:0] = 3'b000;
        exp_out_next[ppi_pin_pkg::PC_BUF_B] =
            (mode == ppi_mode_pkg::MODE_1) && (dir == ppi_mode_pkg::PORT_OUTPUT);
    endtask

    initial begin
        reset = 1'b0;
        forever #(CLK_PERIOD / 2) reset = ~reset;
    end

    initial begin
        #((TEST_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout, the run did not finish within %0d cycles", TEST_CYCLES + 50);
        $display("test failed");
        $finish;
    end

    initial begin
        seed = 32'h260a;
        clock = 1'b1;
        group_a_mode = ppi_mode_pkg::MODE_0;
        group_b_mode = ppi_mode_pkg::MODE_0;
        port_a_dir = ppi_mode_pkg::PORT_INPUT;
        port_b_dir = ppi_mode_pkg::PORT_INPUT;
        port_c_hi_dir = ppi_mode_pkg::PORT_INPUT;
        port_c_lo_dir = ppi_mode_pkg::PORT_INPUT;
        data_bus = 8'h00;
        write_port_a = 1'b0;
        write_port_b = 1'b0;
        write_port_c = 1'b0;
        write_port_c_bit = 1'b0;
        update_group_a_mode = 1'b0;
        update_group_b_mode = 1'b0;
        read_port_a = 1'b0;
        read_port_b = 1'b0;
        port_c_in = 8'h00;
        hs_mask = 8'h00;
        hs_level = HS_PINS;
        exp_out_next = 8'h00;
        out_errors = 0;
        read_errors = 0;
        io_errors = 0;
        pin_errors = 0;
        repeat (RESET_CYCLES) @(negedge reset);
        clock = 1'b0;
        idle(2);

        // Mode 0 with random nibble directions and Group A mode 2 as mode 0
        for (int i = 0; i < MODE0_ROUNDS; i++) begin
            stim = $random(seed);
            write_full(stim[7:0]);
            port_c_hi_dir = stim[8];
            port_c_lo_dir = stim[9];
            group_a_mode = {stim[10], 1'b0};
            write_bit(int'(stim[13:11]), stim[14]);
        end
        group_a_mode = ppi_mode_pkg::MODE_0;
        port_c_hi_dir = ppi_mode_pkg::PORT_OUTPUT;
        port_c_lo_dir = ppi_mode_pkg::PORT_OUTPUT;
        hs_mask = HS_PINS;
        idle(2);

        // Group A strobed input with INTE A on PC4
        set_group_a(ppi_mode_pkg::MODE_1, ppi_mode_pkg::PORT_INPUT);
        write_bit(ppi_pin_pkg::PC_STB_A, 1'b1);
        hs_level[ppi_pin_pkg::PC_STB_A] = 1'b0;
        next_cycle;
        exp_out_next[ppi_pin_pkg::PC_IBF_A] = 1'b1;
        hs_level[ppi_pin_pkg::PC_STB_A] = 1'b1;
        next_cycle;
        exp_out_next[ppi_pin_pkg::PC_INTR_A] = 1'b1;
        next_cycle;
        read_port_a = 1'b1;
        exp_out_next[ppi_pin_pkg::PC_INTR_A] = 1'b0;
        next_cycle;
        read_port_a = 1'b0;
        exp_out_next[ppi_pin_pkg::PC_IBF_A] = 1'b0;
        idle(2);

        // Group A output with INTE A clear so ACK only moves port_a_hiz
        set_group_a(ppi_mode_pkg::MODE_1, ppi_mode_pkg::PORT_OUTPUT);
        idle(1);
        hs_level[ppi_pin_pkg::PC_ACK_A] = 1'b0;
        next_cycle;
        hs_level[ppi_pin_pkg::PC_ACK_A] = 1'b1;
        idle(2);
        set_group_a(ppi_mode_pkg::MODE_0, ppi_mode_pkg::PORT_OUTPUT);

        // Group B acknowledged output with INTE B on PC2
        set_group_b(ppi_mode_pkg::MODE_1, ppi_mode_pkg::PORT_OUTPUT);
        idle(1);
        next_cycle;
        write_port_b = 1'b1;
        exp_out_next[ppi_pin_pkg::PC_BUF_B] = 1'b0;
        exp_out_next[ppi_pin_pkg::PC_INTR_B] = 1'b0;
        write_bit(ppi_pin_pkg::PC_HS_B, 1'b1);
        hs_level[ppi_pin_pkg::PC_HS_B] = 1'b0;
        next_cycle;
        exp_out_next[ppi_pin_pkg::PC_BUF_B] = 1'b1;
        hs_level[ppi_pin_pkg::PC_HS_B] = 1'b1;
        next_cycle;
        exp_out_next[ppi_pin_pkg::PC_INTR_B] = 1'b1;
        idle(2);
        set_group_b(ppi_mode_pkg::MODE_0, ppi_mode_pkg::PORT_OUTPUT);
        idle(3);

        $display("Errors: port_c_out %0d, port_c_read %0d, port_c_io %0d, strobe pins %0d",
                 out_errors, read_errors, io_errors, pin_errors);
        if (out_errors + read_errors + io_errors + pin_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
